/* axi_burst_writer.sv */
`default_nettype none
`timescale 1ns/10ps

module axi_burst_writer (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 head_valid,
   input  axi_wr_pkg::wr_beat_t head_beat,
   output logic                 head_pop,
   output logic                 awvalid,
   output axi_wr_pkg::aw_req_t  aw,
   input  logic                 awready,
   output logic                 wvalid,
   output axi_wr_pkg::w_beat_t  w,
   input  logic                 wready,
   input  logic                 b_done,
   output logic                 in_resp
);

   axi_wr_pkg::writer_state_t state;

   // Burst fields captured from the first beat
   axi_wr_pkg::addr_t addr_q;
   axi_wr_pkg::len_t  len_q;

   axi_wr_pkg::len_t  beat_cnt;
   logic              awvalid_q;
   logic              start;
   logic              w_phase;
   logic              w_xfer;
   logic              last_beat;

   assign start = (state == axi_wr_pkg::idle) && head_valid;
   assign w_phase = (state == axi_wr_pkg::addr_data) || (state == axi_wr_pkg::data);

   // W runs straight off the buffer head
   assign wvalid = w_phase && head_valid;
   assign w_xfer = wvalid && wready;
   assign head_pop = w_xfer;
   assign last_beat = (beat_cnt == len_q);
   assign in_resp = (state == axi_wr_pkg::resp);
   assign awvalid = awvalid_q;

   always_comb begin
      aw.addr = addr_q;
      aw.len = len_q;
      aw.size = axi_wr_pkg::axi_size;
      aw.burst = axi_wr_pkg::axi_burst_incr;
      aw.cache = axi_wr_pkg::axi_cache_val;
      aw.prot = axi_wr_pkg::axi_prot_val;
   end

   always_comb begin
      w.data = head_beat.data;
      w.strb = head_beat.strb;
      w.last = last_beat;
   end

   always_ff @(posedge clk) begin
      if (start) begin
         addr_q <= head_beat.addr;
         len_q <= head_beat.len;
      end
   end

   // FSM
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state <= axi_wr_pkg::idle;
      end else begin
         case (state)
            axi_wr_pkg::idle: begin
               if (head_valid) begin
                  state <= axi_wr_pkg::addr_data;
               end
            end
            axi_wr_pkg::addr_data: begin
               // Last beat may finish before AW; awvalid_q keeps the address up
               if (w_xfer && last_beat) begin
                  state <= axi_wr_pkg::resp;
               end else if (awvalid_q && awready) begin
                  state <= axi_wr_pkg::data;
               end
            end
            axi_wr_pkg::data: begin
               if (w_xfer && last_beat) begin
                  state <= axi_wr_pkg::resp;
               end
            end
            axi_wr_pkg::resp: begin
               if (b_done) begin
                  state <= axi_wr_pkg::idle;
               end
            end
            default: state <= axi_wr_pkg::idle;
         endcase
      end
   end

   // Address valid held until the slave takes it
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         awvalid_q <= 1'b0;
      end else if (start) begin
         awvalid_q <= 1'b1;
      end else if (awready) begin
         awvalid_q <= 1'b0;
      end
   end

   // Beat counter
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         beat_cnt <= '0;
      end else if (start) begin
         beat_cnt <= '0;
      end else if (w_xfer) begin
         beat_cnt <= beat_cnt + axi_wr_pkg::len_w'(1);
      end
   end

endmodule

`default_nettype wire

/* axi_wr_bridge.sv */
`default_nettype none
`timescale 1ns/10ps

module axi_wr_bridge (
   input  logic                   clk,
   input  logic                   rst,
   // Native side
   input  logic                   in_valid,
   input  axi_wr_pkg::wr_beat_t   in_beat,
   output logic                   in_credit,
   // AXI write address
   output logic                   awvalid,
   output axi_wr_pkg::aw_req_t    aw,
   input  logic                   awready,
   // AXI write data
   output logic                   wvalid,
   output axi_wr_pkg::w_beat_t    w,
   input  logic                   wready,
   // AXI write response
   input  logic                   bvalid,
   input  axi_wr_pkg::resp_t      bresp,
   output logic                   bready,
   // Burst result
   output logic                   done,
   output axi_wr_pkg::wr_status_t status
);

   logic                 head_valid;
   axi_wr_pkg::wr_beat_t head_beat;
   logic                 head_pop;
   logic                 b_done;
   logic                 in_resp;

   wr_credit_buffer u_wr_credit_buffer (
      .clk        (clk),
      .rst        (rst),
      .in_valid   (in_valid),
      .in_beat    (in_beat),
      .in_credit  (in_credit),
      .head_valid (head_valid),
      .head_beat  (head_beat),
      .head_pop   (head_pop)
   );

   axi_burst_writer u_axi_burst_writer (
      .clk        (clk),
      .rst        (rst),
      .head_valid (head_valid),
      .head_beat  (head_beat),
      .head_pop   (head_pop),
      .awvalid    (awvalid),
      .aw         (aw),
      .awready    (awready),
      .wvalid     (wvalid),
      .w          (w),
      .wready     (wready),
      .b_done     (b_done),
      .in_resp    (in_resp)
   );

   axi_wr_resp_tracker u_axi_wr_resp_tracker (
      .clk     (clk),
      .rst     (rst),
      .in_resp (in_resp),
      .bvalid  (bvalid),
      .bresp   (bresp),
      .bready  (bready),
      .b_done  (b_done),
      .done    (done),
      .status  (status)
   );

endmodule

`default_nettype wire

/* axi_wr_pkg.sv */
`default_nettype none

package axi_wr_pkg;

   // Bus widths
   localparam int addr_w = 32;
   localparam int data_w = 32;
   localparam int strb_w = data_w / 8;
   localparam int len_w = 8;
   localparam int resp_w = 2;
   localparam int cnt_w = 8;

   // Beat buffer depth, also the initial credit grant
   localparam int buf_depth = 4;
   localparam int ptr_w = $clog2(buf_depth);
   localparam int cred_w = $clog2(buf_depth + 1);

   // Fixed AXI sideband values
   localparam logic [2:0] axi_size = 3'd2;
   localparam logic [1:0] axi_burst_incr = 2'd1;
   localparam logic [3:0] axi_cache_val = 4'd2;
   localparam logic [2:0] axi_prot_val = 3'd2;

   typedef logic [addr_w-1:0] addr_t;
   typedef logic [data_w-1:0] data_t;
   typedef logic [strb_w-1:0] strb_t;
   typedef logic [len_w-1:0] len_t;
   typedef logic [resp_w-1:0] resp_t;
   typedef logic [cnt_w-1:0] cnt_t;

   // Native beat; addr and len only matter on the first beat of a burst
   typedef struct packed {
      addr_t addr;
      len_t  len;
      data_t data;
      strb_t strb;
   } wr_beat_t;

   typedef struct packed {
      addr_t      addr;
      len_t       len;
      logic [2:0] size;
      logic [1:0] burst;
      logic [3:0] cache;
      logic [2:0] prot;
   } aw_req_t;

   typedef struct packed {
      data_t data;
      strb_t strb;
      logic  last;
   } w_beat_t;

   typedef struct packed {
      logic error;
      cnt_t err_count;
   } wr_status_t;

   typedef enum logic [1:0] {
      idle,
      addr_data,
      data,
      resp
   } writer_state_t;

endpackage

`default_nettype wire

/* axi_wr_resp_tracker.sv */
`default_nettype none
`timescale 1ns/10ps

module axi_wr_resp_tracker (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   in_resp,
   input  logic                   bvalid,
   input  axi_wr_pkg::resp_t      bresp,
   output logic                   bready,
   output logic                   b_done,
   output logic                   done,
   output axi_wr_pkg::wr_status_t status
);

   axi_wr_pkg::wr_status_t status_q;

   logic b_xfer;
   logic b_err;
   logic done_q;

   // Only ready while the writer waits for a response
   assign bready = in_resp;
   assign b_xfer = bvalid && bready;
   assign b_err = |bresp;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         done_q <= 1'b0;
      end else begin
         done_q <= b_xfer;
      end
   end

   // Error flag per burst, count saturates at all ones
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         status_q <= '0;
      end else if (b_xfer) begin
         status_q.error <= b_err;
         if (b_err && (status_q.err_count != '1)) begin
            status_q.err_count <= status_q.err_count + axi_wr_pkg::cnt_w'(1);
         end
      end
   end

   // Writer release and outside pulse come from the same edge
   assign b_done = done_q;
   assign done = done_q;
   assign status = status_q;

endmodule

`default_nettype wire

/* axi_wr_vectors.txt */
// Columns in hex: addr, len (beats minus one), bresp, then len+1 data words
// One burst per line; the last line ffffffff ends the list
00001000 00 0 a5a50001
00002040 03 0 11110000 11110001 11110002 11110003
00003000 01 2 22220000 22220001
00004000 07 0 33330000 33330001 33330002 33330003 33330004 33330005 33330006 33330007
00005100 02 3 44440000 44440001 44440002
00006000 00 1 55550000
00007000 04 0 66660000 66660001 66660002 66660003 66660004
00008000 05 2 77770000 77770001 77770002 77770003 77770004 77770005
ffffffff

/* flist.f */
axi_wr_pkg.sv
wr_credit_buffer.sv
axi_burst_writer.sv
axi_wr_resp_tracker.sv
axi_wr_bridge.sv
tb_axi_wr_bridge.sv

/* run_sim.sh */
#!/bin/sh
# Builds the bridge testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/10ps \
   -f flist.f --top-module tb_axi_wr_bridge -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if grep -q "Regression failed" sim.log; then
   exit 1
fi
exit 0

/* tb_axi_wr_bridge.sv */
`default_nettype none
`timescale 1ns/10ps

module tb_axi_wr_bridge;

   localparam int max_words = 256;
   localparam int grant_window = axi_wr_pkg::buf_depth + 4;

   logic                   clk;
   logic                   rst = 1'b1;
   logic                   in_valid = 1'b0;
   axi_wr_pkg::wr_beat_t   in_beat = '0;
   logic                   in_credit;
   logic                   awvalid;
   axi_wr_pkg::aw_req_t    aw;
   logic                   awready = 1'b0;
   logic                   wvalid;
   axi_wr_pkg::w_beat_t    w;
   logic                   wready = 1'b0;
   logic                   bvalid = 1'b0;
   axi_wr_pkg::resp_t      bresp = '0;
   logic                   bready;
   logic                   done;
   axi_wr_pkg::wr_status_t status;

   // Traffic built from the vector file
   logic [31:0]            vec_mem [max_words];
   axi_wr_pkg::wr_beat_t   src_q [$];
   axi_wr_pkg::aw_req_t    exp_aw [$];
   axi_wr_pkg::w_beat_t    exp_w [$];
   axi_wr_pkg::resp_t      exp_resp [$];

   int n_bursts = 0;
   int n_beats = 0;
   int cycle_limit = 1000;
   int rst_cycles = 0;
   int grant_cycles = 0;
   int credits = 0;
   int aw_wait = 0;
   int w_wait = 0;
   int b_wait = -1;
   int aw_cnt = 0;
   int w_last_cnt = 0;
   int b_cnt = 0;
   int done_cnt = 0;
   int exp_errs = 0;
   int burst_mark = 0;
   int check_cnt = 0;
   int err_cnt = 0;
   logic done_prev = 1'b0;

   axi_wr_bridge u_axi_wr_bridge (
      .clk       (clk),
      .rst       (rst),
      .in_valid  (in_valid),
      .in_beat   (in_beat),
      .in_credit (in_credit),
      .awvalid   (awvalid),
      .aw        (aw),
      .awready   (awready),
      .wvalid    (wvalid),
      .w         (w),
      .wready    (wready),
      .bvalid    (bvalid),
      .bresp     (bresp),
      .bready    (bready),
      .done      (done),
      .status    (status)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   task automatic report_fault(input string msg);
      err_cnt++;
      $display("%s, at %0t ns", msg, $time);
   endtask

   task automatic check_aw(input axi_wr_pkg::aw_req_t got, input axi_wr_pkg::aw_req_t exp);
      check_cnt++;
      if (got !== exp) begin
         err_cnt++;
         $display("error at %0t ns: AW got addr %h len %0d size %0d burst %0d cache %0d prot %0d",
                  $time, got.addr, got.len, got.size, got.burst, got.cache, got.prot);
         $display("   expected addr %h len %0d size %0d burst %0d cache %0d prot %0d",
                  exp.addr, exp.len, exp.size, exp.burst, exp.cache, exp.prot);
      end
   endtask

   task automatic check_w(input axi_wr_pkg::w_beat_t got, input axi_wr_pkg::w_beat_t exp);
      check_cnt++;
      if (got !== exp) begin
         err_cnt++;
         $display("error at %0t ns: W got data %h strb %h last %b, expected %h %h %b",
                  $time, got.data, got.strb, got.last, exp.data, exp.strb, exp.last);
      end
   endtask

   task automatic check_status(input axi_wr_pkg::wr_status_t got,
                               input axi_wr_pkg::wr_status_t exp);
      check_cnt++;
      if (got !== exp) begin
         err_cnt++;
         $display("error at %0t ns: status got error %b count %0d, expected %b %0d",
                  $time, got.error, got.err_count, exp.error, exp.err_count);
      end
   endtask

   // Vector lines hold addr, len, bresp and the data words
   task automatic load_vectors();
      int p;
      int i;
      axi_wr_pkg::len_t     len;
      axi_wr_pkg::wr_beat_t beat;
      axi_wr_pkg::aw_req_t  req;
      axi_wr_pkg::w_beat_t  wb;
      $readmemh("axi_wr_vectors.txt", vec_mem);
      p = 0;
      while (p + 3 < max_words && vec_mem[p] != 32'hffff_ffff) begin
         len = axi_wr_pkg::len_t'(vec_mem[p + 1]);
         req.addr = vec_mem[p];
         req.len = len;
         req.size = axi_wr_pkg::axi_size;
         req.burst = axi_wr_pkg::axi_burst_incr;
         req.cache = axi_wr_pkg::axi_cache_val;
         req.prot = axi_wr_pkg::axi_prot_val;
         exp_aw.push_back(req);
         exp_resp.push_back(axi_wr_pkg::resp_t'(vec_mem[p + 2]));
         for (i = 0; i <= int'(len); i++) begin
            beat.addr = req.addr;
            beat.len = len;
            beat.data = vec_mem[p + 3 + i];
            beat.strb = '1;
            src_q.push_back(beat);
            wb.data = beat.data;
            wb.strb = beat.strb;
            wb.last = (i == int'(len));
            exp_w.push_back(wb);
         end
         n_bursts++;
         n_beats = n_beats + int'(len) + 1;
         p = p + 4 + int'(len);
      end
   endtask

   always @(posedge clk) begin
      if (rst_cycles < 8) begin
         rst_cycles <= rst_cycles + 1;
      end
      if (rst_cycles == 7) begin
         rst <= 1'b0;
      end
   end

   // Native source waits out the initial grant before spending credits
   always @(posedge clk) begin
      if (!rst) begin
         credits = credits + int'(in_credit);
         if (credits > axi_wr_pkg::buf_depth) begin
            report_fault("more credits returned than buffer slots");
         end
         if (grant_cycles < grant_window) begin
            grant_cycles = grant_cycles + 1;
            in_valid <= 1'b0;
            if (awvalid || wvalid || bready || done || status != '0) begin
               report_fault("bridge output active before any beat was sent");
            end
            if (grant_cycles == grant_window) begin
               if (credits != axi_wr_pkg::buf_depth) begin
                  report_fault("initial credit count differs from buffer depth");
               end
               $display("reset: %0d initial credits, %s", credits,
                        (err_cnt == 0) ? "pass" : "fail");
               burst_mark = err_cnt;
            end
         end else if (src_q.size() != 0 && credits > 0 && ($urandom % 4) != 0) begin
            in_valid <= 1'b1;
            in_beat <= src_q.pop_front();
            credits = credits - 1;
         end else begin
            in_valid <= 1'b0;
         end
      end
   end

   // AXI slave address channel
   always @(posedge clk) begin
      if (!rst) begin
         if (awvalid && awready) begin
            if (exp_aw.size() == 0) begin
               report_fault("AW transfer with no burst left to send");
            end else begin
               check_aw(aw, exp_aw.pop_front());
            end
            if (aw_cnt != done_cnt) begin
               report_fault("AW issued while an earlier burst was still open");
            end
            aw_cnt <= aw_cnt + 1;
            awready <= 1'b0;
            aw_wait = int'($urandom % 4);
         end else if (awvalid) begin
            if (aw_wait == 0) begin
               awready <= 1'b1;
            end else begin
               aw_wait = aw_wait - 1;
            end
         end
      end
   end

   // AXI slave data channel with random stalls
   always @(posedge clk) begin
      if (!rst) begin
         if (wvalid && wready) begin
            if (exp_w.size() == 0) begin
               report_fault("W beat with no beat left to send");
            end else begin
               check_w(w, exp_w.pop_front());
            end
            if (w.last) begin
               w_last_cnt <= w_last_cnt + 1;
            end
            w_wait = int'($urandom % 4);
            if (w_wait != 0) begin
               wready <= 1'b0;
            end
         end else if (wvalid && !wready) begin
            if (w_wait <= 1) begin
               wready <= 1'b1;
            end else begin
               w_wait = w_wait - 1;
            end
         end
      end
   end

   // AXI slave responds only after both AW and the last W of the burst
   always @(posedge clk) begin
      if (!rst) begin
         // The writer leaves resp in the cycle done is high
         if (bready && !done && w_last_cnt == b_cnt) begin
            report_fault("bready high with no burst waiting for a response");
         end
         if (bvalid && bready) begin
            bvalid <= 1'b0;
            b_cnt <= b_cnt + 1;
            b_wait = -1;
         end else if (!bvalid && aw_cnt > b_cnt && w_last_cnt > b_cnt) begin
            if (b_wait < 0) begin
               b_wait = int'($urandom % 4);
            end else if (b_wait == 0) begin
               bvalid <= 1'b1;
               bresp <= exp_resp[b_cnt];
               b_wait = -1;
            end else begin
               b_wait = b_wait - 1;
            end
         end
      end
   end

   // Burst results
   always @(posedge clk) begin
      axi_wr_pkg::wr_status_t exp_st;
      if (!rst && done) begin
         if (done_prev) begin
            report_fault("done held high for more than one cycle");
         end
         if (done_cnt >= b_cnt) begin
            report_fault("done pulse without a B transfer");
         end
         if (done_cnt >= n_bursts) begin
            report_fault("done pulse after the last burst");
         end else begin
            exp_st.error = |exp_resp[done_cnt];
            if (exp_st.error) begin
               exp_errs = exp_errs + 1;
            end
            exp_st.err_count = axi_wr_pkg::cnt_t'(exp_errs);
            check_status(status, exp_st);
            $display("burst %0d: bresp %0d, error count %0d, %s", done_cnt,
                     exp_resp[done_cnt], exp_errs, (err_cnt == burst_mark) ? "pass" : "fail");
            burst_mark = err_cnt;
         end
         done_cnt <= done_cnt + 1;
      end
      done_prev = done;
   end

   initial begin : main
      int drain_mark;
      void'($urandom(99));
      load_vectors();
      if (n_bursts == 0) begin
         report_fault("no bursts read from the vector file");
      end
      // Run length follows the beat count
      cycle_limit = n_beats * 16 + 200;
      while (done_cnt < n_bursts) begin
         @(posedge clk);
      end
      repeat (4) @(posedge clk);
      @(negedge clk);
      drain_mark = err_cnt;
      if (credits != axi_wr_pkg::buf_depth) begin
         report_fault("credits not all returned after the last burst");
      end
      if (exp_w.size() != 0) begin
         report_fault("W beats still missing at the end");
      end
      if (aw_cnt != n_bursts) begin
         report_fault("AW transfer count differs from the burst count");
      end
      $display("drain: %0d credits back, %s", credits, (err_cnt == drain_mark) ? "pass" : "fail");
      $display("summary: %0d bursts, %0d beats, %0d checks, %0d errors",
               n_bursts, n_beats, check_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

   initial begin : watchdog
      int cycles;
      cycles = 0;
      @(posedge clk);
      while (cycles < cycle_limit) begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout: run still going after %0d cycles", cycles);
      $display("Regression failed");
      $finish;
   end

endmodule

`default_nettype wire

/* wr_credit_buffer.sv */
`default_nettype none
`timescale 1ns/10ps

module wr_credit_buffer (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 in_valid,
   input  axi_wr_pkg::wr_beat_t in_beat,
   output logic                 in_credit,
   output logic                 head_valid,
   output axi_wr_pkg::wr_beat_t head_beat,
   input  logic                 head_pop
);

   axi_wr_pkg::wr_beat_t mem [axi_wr_pkg::buf_depth];

   logic [axi_wr_pkg::ptr_w-1:0]  wr_ptr;
   logic [axi_wr_pkg::ptr_w-1:0]  rd_ptr;
   logic [axi_wr_pkg::cred_w-1:0] fill;
   logic [axi_wr_pkg::cred_w-1:0] cred_cnt;
   logic [axi_wr_pkg::cred_w-1:0] cred_sum;
   logic                          cred_out;

   // Beat storage
   always_ff @(posedge clk) begin
      if (in_valid) begin
         mem[wr_ptr] <= in_beat;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         fill <= '0;
      end else begin
         if (in_valid) begin
            wr_ptr <= wr_ptr + axi_wr_pkg::ptr_w'(1);
         end
         if (head_pop) begin
            rd_ptr <= rd_ptr + axi_wr_pkg::ptr_w'(1);
         end
         case ({in_valid, head_pop})
            2'b10:   fill <= fill + axi_wr_pkg::cred_w'(1);
            2'b01:   fill <= fill - axi_wr_pkg::cred_w'(1);
            default: fill <= fill;
         endcase
      end
   end

   assign head_valid = (fill != '0);
   assign head_beat = mem[rd_ptr];

   // Credits still owed to the source, starting with the full depth.
   // A pop during the initial release is queued behind it.
   assign cred_sum = cred_cnt + axi_wr_pkg::cred_w'(head_pop);
   assign cred_out = (cred_sum != '0);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         cred_cnt <= axi_wr_pkg::cred_w'(axi_wr_pkg::buf_depth);
         in_credit <= 1'b0;
      end else begin
         cred_cnt <= cred_sum - axi_wr_pkg::cred_w'(cred_out);
         in_credit <= cred_out;
      end
   end

endmodule

`default_nettype wire
